// ==== compile.f ====
logic/isaPkg.sv
logic/pipePkg.sv
logic/instrDecode.sv
logic/regFile.sv
logic/hazardDetect.sv
logic/issueStage.sv
logic/issueTop.sv
bench/issueTb.sv

// ==== Bender.yml ====
package:
  name: issue_stage

dependencies: {}

sources:
  # Packages first, then the design in dependency order
  - logic/isaPkg.sv
  - logic/pipePkg.sv
  - logic/instrDecode.sv
  - logic/regFile.sv
  - logic/hazardDetect.sv
  - logic/issueStage.sv
  - logic/issueTop.sv

  # Testbench, top module issueTb
  - target: test
    files:
      - bench/issueTb.sv

export_include_dirs: []

# Simulation top: issueTb, synthesis top: issueTop

// ==== bench/issueTb.sv ====
`default_nettype none
`timescale 1ns/1ps

module issueTb;
    import isaPkg::*;
    import pipePkg::*;

    // Row groups, used in error lines
    localparam logic [2:0] gIndep = 3'd0;
    localparam logic [2:0] gDep   = 3'd1;
    localparam logic [2:0] gMem   = 3'd2;
    localparam logic [2:0] gCtrl  = 3'd3;
    localparam logic [2:0] gNop   = 3'd4;
    localparam logic [2:0] gBack  = 3'd5;

    typedef struct packed {
        instrWord    word;
        logic [2:0]  group;
        logic [3:0]  minGap;
        logic [3:0]  exactGap;
        logic        checkAddr;
        logic [15:0] addr;
    } stimRow;

    logic       clk;
    logic       reset;
    logic       inValid;
    instrWord   inInstr;
    logic       inCredit;
    logic       outValid;
    issuePacket outPacket;
    logic       outCredit;
    logic       wbEnable;
    regIdx      wbReg;
    logic [15:0] wbData;

    logic [15:0] regInit [8] = '{16'h0000, 16'h0100, 16'h0200, 16'h0040,
                                 16'h1000, 16'h0010, 16'h0abc, 16'h0123};
    stimRow stim [$];
    int     dueQ [$];
    logic [31:0] rngState = 32'h67ef_ecca;
    logic   holdCredits;
    int     pushEnd;
    int     pushCount = 0;
    int     upCredit;
    int     cycle = 0;
    int     timeoutLimit;
    int     issuedCount = 0;
    int     creditPulses = 0;
    int     outIdx = 0;
    int     lastIssue = 0;
    logic   prevCtrl = 1'b0;
    int     valueErrors = 0;
    int     otherErrors = 0;

    issueTop DUT (
        .clk       (clk),
        .reset     (reset),
        .inValid   (inValid),
        .inInstr   (inInstr),
        .inCredit  (inCredit),
        .outValid  (outValid),
        .outPacket (outPacket),
        .outCredit (outCredit),
        .wbEnable  (wbEnable),
        .wbReg     (wbReg),
        .wbData    (wbData)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic instrWord aluWord(input regIdx rd, input regIdx rs, input regIdx rt);
        instrWord w;
        w.r.opcode = opAlu;
        w.r.rs = rs;
        w.r.rt = rt;
        w.r.rd = rd;
        w.r.func = 2'b00;
        return w;
    endfunction

    function automatic instrWord immWord(input logic [4:0] opc, input regIdx rd,
                                         input regIdx rs, input logic [4:0] imm);
        instrWord w;
        w.i.opcode = opc;
        w.i.rs = rs;
        w.i.rd = rd;
        w.i.imm = imm;
        return w;
    endfunction

    function automatic logic isNopWord(input instrWord w);
        return w.i.opcode == opNop;
    endfunction

    // Jump group 001xx and branch group 011xx
    function automatic logic isCtrlWord(input instrWord w);
        return (w.i.opcode[4:2] == 3'b001) || (w.i.opcode[4:2] == 3'b011);
    endfunction

    function automatic string groupName(input logic [2:0] g);
        case (g)
            gIndep:  return "independent";
            gDep:    return "dependent";
            gMem:    return "memory";
            gCtrl:   return "ctrlflow";
            gNop:    return "nop";
            default: return "backpressure";
        endcase
    endfunction

    function automatic int countIssues(input int last);
        int n;
        n = 0;
        for (int k = 0; k < last; k++) begin
            if (!isNopWord(stim[k].word)) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic addRow(input instrWord word, input logic [2:0] group, input int minGap,
                          input int exactGap, input logic checkAddr);
        stimRow row;
        row.word = word;
        row.group = group;
        row.minGap = 4'(minGap);
        row.exactGap = 4'(exactGap);
        row.checkAddr = checkAddr;
        // Base plus signed immediate from the pre-loaded registers
        row.addr = regInit[word.i.rs] + 16'($signed(word.i.imm));
        stim.push_back(row);
    endtask

    task automatic buildStimulus(output int splitIdx);
        addRow(aluWord(6, 1, 2), gIndep, 0, 0, 0);
        addRow(immWord(opAddi, 7, 3, 5'd5), gIndep, 1, 1, 0);
        addRow(aluWord(6, 4, 5), gIndep, 1, 1, 0);
        addRow(immWord(opAddi, 7, 1, 5'b11101), gIndep, 1, 1, 0);
        // Read after write on r2, then on r3
        addRow(immWord(opAddi, 2, 3, 5'd1), gDep, 1, 1, 0);
        addRow(aluWord(6, 2, 1), gDep, 5, 5, 0);
        addRow(immWord(opAddi, 3, 5, 5'd2), gDep, 1, 1, 0);
        addRow(immWord(opAddi, 7, 3, 5'd0), gDep, 5, 5, 0);
        // Same address held, different address streams
        addRow(immWord(opLoad, 6, 4, 5'd4), gMem, 1, 1, 1);
        addRow(immWord(opStore, 5, 4, 5'd4), gMem, 5, 5, 1);
        addRow(immWord(opLoad, 6, 1, 5'b11110), gMem, 1, 1, 1);
        addRow(immWord(opStore, 5, 2, 5'd6), gMem, 1, 1, 1);
        addRow(immWord(opJr, 0, 1, 5'd0), gCtrl, 1, 1, 0);
        addRow(immWord(opAddi, 7, 5, 5'd1), gCtrl, 2, 2, 0);
        addRow(immWord(5'b00100, 0, 3, 5'd0), gCtrl, 1, 1, 0);
        addRow(immWord(5'b01100, 0, 2, 5'd2), gCtrl, 2, 2, 0);
        // NOP waits out the branch bubble, then drops
        addRow(immWord(opNop, 0, 0, 5'd0), gNop, 0, 0, 0);
        addRow(immWord(opAddi, 6, 1, 5'd3), gNop, 3, 3, 0);
        splitIdx = stim.size();
        addRow(aluWord(6, 1, 2), gBack, 0, 0, 0);
        addRow(immWord(opAddi, 7, 3, 5'd1), gBack, 1, 1, 0);
        addRow(aluWord(6, 4, 5), gBack, 1, 1, 0);
        addRow(immWord(opAddi, 7, 2, 5'd2), gBack, 1, 1, 0);
        // Held for the whole credit stall, then back to back
        addRow(aluWord(6, 1, 3), gBack, 12, 0, 0);
        addRow(immWord(opAddi, 7, 4, 5'd7), gBack, 1, 1, 0);
    endtask

    task automatic reportValue(input int idx, input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        $display("ERROR %s entry %0d %s: expected %h, actual %h",
                 groupName(stim[idx].group), idx, what, expected, actual);
        valueErrors++;
    endtask

    task automatic finishRun();
        $display("Closing counts: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    task automatic preloadRegisters();
        for (int r = 0; r < 8; r++) begin
            @(posedge clk);
            wbEnable <= 1'b1;
            wbReg <= regIdx'(r);
            wbData <= regInit[r];
        end
        @(posedge clk);
        wbEnable <= 1'b0;
    endtask

    // Upstream keeps its own credit count
    always @(posedge clk) begin
        if (reset) begin
            inValid <= 1'b0;
            upCredit = upCredits;
        end else begin
            if (inCredit) begin
                upCredit++;
            end
            if (pushCount < pushEnd && upCredit > 0) begin
                inValid <= 1'b1;
                inInstr <= stim[pushCount].word;
                pushCount++;
                upCredit--;
            end else begin
                inValid <= 1'b0;
            end
        end
    end

    // Downstream returns one credit per cycle, each after 1 to 3 cycles
    always @(posedge clk) begin
        if (reset) begin
            outCredit <= 1'b0;
        end else begin
            if (outValid) begin
                rngState = lcgNext(rngState);
                dueQ.push_back(cycle + 1 + int'((rngState >> 16) % 3));
            end
            if (!holdCredits && dueQ.size() > 0 && dueQ[0] <= cycle + 1) begin
                outCredit <= 1'b1;
                void'(dueQ.pop_front());
            end else begin
                outCredit <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeoutLimit) begin
            $display("Run stopped at cycle %0d before all entries were issued", cycle);
            otherErrors++;
            finishRun();
        end
    end

    // Output monitor, sampled before the edge updates
    always @(posedge clk) begin
        stimRow row;
        int gap;
        if (!reset) begin
            if (inCredit) begin
                creditPulses <= creditPulses + 1;
            end
            if (prevCtrl && outValid) begin
                $display("Issue in the slot right after a control-flow op at cycle %0d", cycle);
                otherErrors++;
            end
            prevCtrl = 1'b0;
            if (outValid) begin
                while (outIdx < stim.size() && isNopWord(stim[outIdx].word)) begin
                    outIdx++;
                end
                if (outIdx >= stim.size()) begin
                    $display("Issue at cycle %0d with no table entry left", cycle);
                    otherErrors++;
                end else begin
                    row = stim[outIdx];
                    gap = cycle - lastIssue;
                    if (outPacket.instr !== row.word) begin
                        reportValue(outIdx, "instr", row.word, outPacket.instr);
                    end
                    if (row.exactGap != 0 && gap != row.exactGap) begin
                        reportValue(outIdx, "gap", 16'(row.exactGap), 16'(gap));
                    end
                    if (row.minGap != 0 && gap < row.minGap) begin
                        $display("ERROR %s entry %0d gap: expected >= %0d, actual %0d",
                                 groupName(row.group), outIdx, row.minGap, gap);
                        valueErrors++;
                    end
                    if (row.checkAddr) begin
                        if (outPacket.memAddr !== row.addr) begin
                            reportValue(outIdx, "memAddr", row.addr, outPacket.memAddr);
                        end
                        if (outPacket.base !== regInit[row.word.i.rs]) begin
                            reportValue(outIdx, "base", regInit[row.word.i.rs], outPacket.base);
                        end
                    end
                    outIdx++;
                end
                lastIssue = cycle;
                prevCtrl = isCtrlWord(outPacket.instr);
                issuedCount <= issuedCount + 1;
            end
        end
    end

    initial begin
        int splitIdx;
        int issuesA;
        int issuesAll;
        clk = 1'b0;
        reset = 1'b1;
        inValid = 1'b0;
        inInstr = '0;
        outCredit = 1'b0;
        wbEnable = 1'b0;
        wbReg = '0;
        wbData = '0;
        holdCredits = 1'b0;
        pushEnd = 0;
        buildStimulus(splitIdx);
        timeoutLimit = stim.size() * 12 + 100;
        issuesA = countIssues(splitIdx);
        issuesAll = countIssues(stim.size());
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        preloadRegisters();
        pushEnd <= splitIdx;
        while (issuedCount < issuesA) begin
            @(posedge clk);
        end
        // Credits come home and the shadow drains
        repeat (8) @(posedge clk);
        holdCredits <= 1'b1;
        pushEnd <= stim.size();
        while (issuedCount < issuesA + downCredits) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        if (issuedCount - issuesA != downCredits) begin
            $display("ERROR backpressure issues without credit: expected %0d, actual %0d",
                     downCredits, issuedCount - issuesA);
            valueErrors++;
        end
        holdCredits <= 1'b0;
        while (issuedCount < issuesAll) begin
            @(posedge clk);
        end
        repeat (6) @(posedge clk);
        if (creditPulses != pushCount) begin
            $display("ERROR nop inCredit pulses: expected %0d, actual %0d",
                     pushCount, creditPulses);
            valueErrors++;
        end
        if (issuedCount != issuesAll) begin
            $display("ERROR backpressure total issues: expected %0d, actual %0d",
                     issuesAll, issuedCount);
            valueErrors++;
        end
        finishRun();
    end

endmodule

`default_nettype wire

// ==== logic/issueTop.sv ====
`default_nettype none
`timescale 1ns/1ps

module issueTop (
    input  logic                clk,
    input  logic                reset,
    input  logic                inValid,
    input  isaPkg::instrWord    inInstr,
    output logic                inCredit,
    output logic                outValid,
    output pipePkg::issuePacket outPacket,
    input  logic                outCredit,
    input  logic                wbEnable,
    input  isaPkg::regIdx       wbReg,
    input  logic [15:0]         wbData
);
    import isaPkg::*;

    instrWord    headInstr;
    decodedOp    headOp;
    logic [15:0] baseData;
    logic [15:0] memAddr;
    logic        stall;
    logic        shadowBubble;
    logic        issueFire;

    instrDecode decode (
        .word (headInstr),
        .op   (headOp)
    );

    // Base register for the address is always rs
    regFile regs (
        .clk      (clk),
        .reset    (reset),
        .readReg  (headOp.rs),
        .readData (baseData),
        .wbEnable (wbEnable),
        .wbReg    (wbReg),
        .wbData   (wbData)
    );

    hazardDetect hazard (
        .clk          (clk),
        .reset        (reset),
        .head         (headOp),
        .baseData     (baseData),
        .issueFire    (issueFire),
        .stall        (stall),
        .shadowBubble (shadowBubble),
        .memAddr      (memAddr)
    );

    issueStage issue (
        .clk          (clk),
        .reset        (reset),
        .inValid      (inValid),
        .inInstr      (inInstr),
        .inCredit     (inCredit),
        .headInstr    (headInstr),
        .headOp       (headOp),
        .stall        (stall),
        .shadowBubble (shadowBubble),
        .memAddr      (memAddr),
        .baseData     (baseData),
        .issueFire    (issueFire),
        .outValid     (outValid),
        .outPacket    (outPacket),
        .outCredit    (outCredit)
    );

endmodule

`default_nettype wire

// ==== logic/issueStage.sv ====
`default_nettype none
`timescale 1ns/1ps

module issueStage (
    input  logic               clk,
    input  logic               reset,
    input  logic               inValid,
    input  isaPkg::instrWord   inInstr,
    output logic               inCredit,
    output isaPkg::instrWord   headInstr,
    input  isaPkg::decodedOp   headOp,
    input  logic               stall,
    input  logic               shadowBubble,
    input  logic [15:0]        memAddr,
    input  logic [15:0]        baseData,
    output logic               issueFire,
    output logic               outValid,
    output pipePkg::issuePacket outPacket,
    input  logic               outCredit
);
    import isaPkg::*;
    import pipePkg::*;

    instrWord queue [upCredits];
    logic [queueBits-1:0]  fillCount;
    logic [creditBits-1:0] creditCount;
    logic headValid;
    logic nopDrop;
    logic pop;
    logic writeSlot;

    assign headValid = fillCount != '0;
    assign headInstr = queue[0];

    assign issueFire = headValid && !headOp.isNop && !stall && !shadowBubble &&
                       (creditCount != '0);
    // NOPs leave the queue without using a downstream credit
    assign nopDrop = headValid && headOp.isNop && !shadowBubble;
    assign pop = issueFire || nopDrop;
    assign inCredit = pop;

    // Slot for an incoming word after any pop has shifted the queue
    assign writeSlot = fillCount == (pop ? queueBits'(2) : queueBits'(1));

    always_ff @(posedge clk) begin
        if (pop) begin
            queue[0] <= queue[1];
        end
        if (inValid) begin
            queue[writeSlot] <= inInstr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fillCount   <= '0;
            creditCount <= creditBits'(downCredits);
        end else begin
            fillCount   <= fillCount + queueBits'(inValid) - queueBits'(pop);
            creditCount <= creditCount + creditBits'(outCredit) - creditBits'(issueFire);
        end
    end

    assign outValid = issueFire;
    assign outPacket.instr   = headInstr;
    assign outPacket.memAddr = memAddr;
    assign outPacket.base    = baseData;

    noPushWhenFull: assert property (
        @(posedge clk) disable iff (reset)
        inValid |-> (fillCount != queueBits'(upCredits))
    ) else $error("Push into a full queue");

    creditBound: assert property (
        @(posedge clk) disable iff (reset)
        creditCount <= creditBits'(downCredits)
    ) else $error("Downstream credit above its initial value");

endmodule

`default_nettype wire

// ==== logic/hazardDetect.sv ====
`default_nettype none
`timescale 1ns/1ps

module hazardDetect (
    input  logic             clk,
    input  logic             reset,
    input  isaPkg::decodedOp head,
    input  logic [15:0]      baseData,
    input  logic             issueFire,
    output logic             stall,
    output logic             shadowBubble,
    output logic [15:0]      memAddr
);
    import pipePkg::*;

    // Slot 0 is ID, then EX, MEM and WB
    stageRecord shadow [trackDepth];
    stageRecord nextRecord;

    logic [trackDepth-1:0] regHit;
    logic [trackDepth-1:0] memHit;

    // Effective address of the head
    assign memAddr = baseData + head.imm;

    // Bubble record unless the head issues this cycle
    always_comb begin
        nextRecord = '0;
        if (issueFire) begin
            nextRecord.valid     = 1'b1;
            nextRecord.writesReg = head.writesReg;
            nextRecord.rd        = head.rd;
            nextRecord.memEnable = head.memEnable;
            nextRecord.memAddr   = memAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < trackDepth; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            shadow[0] <= nextRecord;
            for (int i = 1; i < trackDepth; i++) begin
                shadow[i] <= shadow[i-1];
            end
        end
    end

    // Per-stage matching of sources and address
    always_comb begin
        for (int s = 0; s < trackDepth; s++) begin
            regHit[s] = shadow[s].valid && shadow[s].writesReg &&
                        ((head.useRs && (shadow[s].rd == head.rs)) ||
                         (head.useRt && (shadow[s].rd == head.rt)));
            memHit[s] = shadow[s].valid && shadow[s].memEnable && head.memEnable &&
                        (shadow[s].memAddr == memAddr);
        end
    end

    assign stall = (|regHit) || (|memHit);

    // One dead slot after a jump, jr or branch
    always_ff @(posedge clk) begin
        if (reset) begin
            shadowBubble <= 1'b0;
        end else begin
            shadowBubble <= issueFire && head.ctrlFlow;
        end
    end

    noIssueOnHazard: assert property (
        @(posedge clk) disable iff (reset)
        !(stall && issueFire)
    ) else $error("Issue while a hazard is open");

    bubbleAfterCtrlFlow: assert property (
        @(posedge clk) disable iff (reset)
        (issueFire && head.ctrlFlow) |=> !issueFire
    ) else $error("Issue in the slot after a control-flow op");

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`default_nettype none
`timescale 1ns/1ps

module regFile (
    input  logic          clk,
    input  logic          reset,
    input  isaPkg::regIdx readReg,
    output logic [15:0]   readData,
    input  logic          wbEnable,
    input  isaPkg::regIdx wbReg,
    input  logic [15:0]   wbData
);
    import isaPkg::*;

    logic [15:0] regs [regCount];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEnable) begin
            regs[wbReg] <= wbData;
        end
    end

    // Returns the stored value
    // A write in this cycle shows up from the next one
    assign readData = regs[readReg];

endmodule

`default_nettype wire

// ==== logic/instrDecode.sv ====
`default_nettype none
`timescale 1ns/1ps

module instrDecode (
    input  isaPkg::instrWord word,
    output isaPkg::decodedOp op
);
    import isaPkg::*;

    always_comb begin
        op = '0;
        op.word = word;
        // rs sits at the same bits in both formats
        op.rs = word.i.rs;
        op.rt = word.r.rt;
        op.rd = word.i.rd;
        op.imm = {{11{word.i.imm[4]}}, word.i.imm};

        case (word.r.opcode) inside
            opNop: begin
                op.isNop = 1'b1;
            end
            opAlu: begin
                op.useRs = 1'b1;
                op.useRt = 1'b1;
                op.writesReg = 1'b1;
                op.rd = word.r.rd;
                op.imm = '0;
            end
            opAddi: begin
                op.useRs = 1'b1;
                op.writesReg = 1'b1;
            end
            opLoad: begin
                op.useRs = 1'b1;
                op.writesReg = 1'b1;
                op.memEnable = 1'b1;
            end
            opStore: begin
                // Store data sits in the rd field, on the rt bits
                op.useRs = 1'b1;
                op.useRt = 1'b1;
                op.memEnable = 1'b1;
            end
            opJr,
            [{jumpPrefix, 2'b00} : {jumpPrefix, 2'b10}],
            [{branchPrefix, 2'b00} : {branchPrefix, 2'b11}]: begin
                op.useRs = 1'b1;
                op.ctrlFlow = 1'b1;
            end
            default: begin
                // Unknown opcodes pass as plain ops with no effects
            end
        endcase
    end

    nopHasNoEffect: assert final (!op.isNop || (!op.writesReg && !op.memEnable))
        else $error("NOP decoded with a register or memory effect");

endmodule

`default_nettype wire

// ==== logic/pipePkg.sv ====
`default_nettype none

package pipePkg;

    // Queue depth and the upstream's starting credit
    localparam int upCredits = 2;

    // Starting credit towards execute
    localparam int downCredits = 4;

    // Tracked stages ID, EX, MEM, WB
    localparam int trackDepth = 4;

    localparam int queueBits  = $clog2(upCredits + 1);
    localparam int creditBits = $clog2(downCredits + 1);

    typedef struct packed {
        logic          valid;
        logic          writesReg;
        isaPkg::regIdx rd;
        logic          memEnable;
        logic [15:0]   memAddr;
    } stageRecord;

    typedef struct packed {
        isaPkg::instrWord instr;
        logic [15:0]      memAddr;
        logic [15:0]      base;
    } issuePacket;

endpackage

`default_nettype wire

// ==== logic/isaPkg.sv ====
`default_nettype none

package isaPkg;

    localparam int regCount = 8;

    typedef logic [2:0] regIdx;

    // Opcode field in bits 15 to 11
    localparam logic [4:0] opNop   = 5'b00001;
    localparam logic [4:0] opJr    = 5'b00111;
    localparam logic [4:0] opAddi  = 5'b01000;
    localparam logic [4:0] opStore = 5'b10000;
    localparam logic [4:0] opLoad  = 5'b10001;
    localparam logic [4:0] opAlu   = 5'b11011;

    // Top three opcode bits of the jump and branch groups
    localparam logic [2:0] jumpPrefix   = 3'b001;
    localparam logic [2:0] branchPrefix = 3'b011;

    typedef struct packed {
        logic [4:0] opcode;
        regIdx      rs;
        regIdx      rt;
        regIdx      rd;
        logic [1:0] func;
    } rFormat;

    typedef struct packed {
        logic [4:0] opcode;
        regIdx      rs;
        regIdx      rd;
        logic [4:0] imm;
    } iFormat;

    // One instruction word seen through either format
    typedef union packed {
        rFormat r;
        iFormat i;
    } instrWord;

    typedef struct packed {
        logic        useRs;
        regIdx       rs;
        logic        useRt;
        regIdx       rt;
        logic        writesReg;
        regIdx       rd;
        logic [15:0] imm;
        logic        memEnable;
        logic        isNop;
        logic        ctrlFlow;
        instrWord    word;
    } decodedOp;

endpackage

`default_nettype wire
